/* verilog/npc_pkg.sv */
// shared widths, operation enums and stage payload structs for the npc core and its testbench
package npc_pkg;

	// ******************************************************************
	// widths and addresses
	// ******************************************************************

	localparam int XLEN = 64;
	// register index width, 32 integer registers
	localparam int GPR_AW = 5;
	localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

	// major opcodes of the supported subset
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// ******************************************************************
	// operations
	// ******************************************************************

	// one entry per decoded instruction, op_nop for anything unknown
	typedef enum logic [4:0] {
		op_add, op_sub, op_and, op_or, op_xor,
		op_slt, op_sltu, op_sll, op_srl, op_sra,
		op_addi, op_andi, op_ori, op_xori,
		op_slti, op_sltiu, op_slli, op_srli, op_srai,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lui, op_auipc, op_jal, op_jalr,
		op_nop
	} inst_op_e;

	// alu functions, pass_b forwards operand b (lui)
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
		alu_pass_b
	} alu_op_e;

	// ******************************************************************
	// stage payloads
	// ******************************************************************

	// fetch to decode, qualified by valid_if_id
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
	} fetch_s;

	// decode to execute
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		inst_op_e          op;
		alu_op_e           alu;
		logic [XLEN-1:0]   opa;
		logic [XLEN-1:0]   opb;
		// rs2 value, branch compare only
		logic [XLEN-1:0]   src2;
		logic [XLEN-1:0]   imm;
		logic [GPR_AW-1:0] rd;
		logic              wen;
	} issue_s;

	// execute back to fetch and decode
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] target;
	} redirect_s;

	// execute to writeback
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [GPR_AW-1:0] rd;
		logic              wen;
		logic [XLEN-1:0]   value;
	} result_s;

	// one per retired instruction, wen low for rd x0
	typedef struct packed {
		logic              valid;
		logic [XLEN-1:0]   pc;
		logic [GPR_AW-1:0] rd;
		logic              wen;
		logic [XLEN-1:0]   value;
	} commit_s;

endpackage

/* verilog/npc_gpr.sv */
// integer register file: x0 reads zero, one write port, two asynchronous read ports
`timescale 1ns/1ps

module npc_gpr (
	input  logic                       clk,
	input  logic                       wen,
	input  logic [npc_pkg::GPR_AW-1:0] waddr,
	input  logic [npc_pkg::XLEN-1:0]   wdata,
	input  logic [npc_pkg::GPR_AW-1:0] raddr1,
	input  logic [npc_pkg::GPR_AW-1:0] raddr2,
	output logic [npc_pkg::XLEN-1:0]   rdata1,
	output logic [npc_pkg::XLEN-1:0]   rdata2
);
	import npc_pkg::*;

	// x1 to x31, no storage for x0
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	// reads see the old value in the write cycle
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* verilog/npc_ifu.sv */
// fetch stage: pc register, instruction memory address and the fetch to decode register
`timescale 1ns/1ps

module npc_ifu (
	input  logic                     clk,
	input  logic                     rst,
	input  npc_pkg::redirect_s       redirect,
	input  logic                     ready_if_id,
	input  logic [31:0]              imem_data,
	output logic [npc_pkg::XLEN-1:0] imem_addr,
	output logic                     valid_if_id,
	output npc_pkg::fetch_s          fetch
);
	import npc_pkg::*;

	logic [XLEN-1:0] pc;
	// stage empty or being taken by decode
	logic            advance;

	assign advance = !valid_if_id || ready_if_id;
	// memory answers in the same cycle
	assign imem_addr = pc;

	// pc and stage valid
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
			valid_if_id <= 1'b0;
		end else if (redirect.valid) begin
			// held instruction is wrong path
			pc <= redirect.target;
			valid_if_id <= 1'b0;
		end else if (advance) begin
			pc <= pc + XLEN'(4);
			valid_if_id <= 1'b1;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (!redirect.valid && advance) begin
			fetch.pc <= pc;
			fetch.inst <= imem_data;
		end
	end

	// decode stall must freeze the offered instruction
	a_fetch_hold : assert property (@(posedge clk) disable iff (rst)
		valid_if_id && !ready_if_id && !redirect.valid |=> valid_if_id && $stable(fetch))
		else $error("fetch payload changed while stalled");

endmodule

/* verilog/npc_idu.sv */
// decode stage: instruction decode, operand select, scoreboard stall and the issue register
`timescale 1ns/1ps

module npc_idu (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       valid_if_id,
	input  npc_pkg::fetch_s            fetch,
	input  npc_pkg::redirect_s         redirect,
	input  logic [npc_pkg::XLEN-1:0]   rs1_data,
	input  logic [npc_pkg::XLEN-1:0]   rs2_data,
	input  logic [31:0]                busy,
	output logic                       ready_if_id,
	output logic [npc_pkg::GPR_AW-1:0] rs1_addr,
	output logic [npc_pkg::GPR_AW-1:0] rs2_addr,
	output npc_pkg::issue_s            issue
);
	import npc_pkg::*;

	logic [31:0]       inst;
	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [GPR_AW-1:0] rd;
	logic [XLEN-1:0]   imm_i;
	logic [XLEN-1:0]   imm_u;
	logic [XLEN-1:0]   imm_j;
	logic [XLEN-1:0]   imm_b;
	inst_op_e          dec_op;
	alu_op_e           dec_alu;
	logic [XLEN-1:0]   dec_opa;
	logic [XLEN-1:0]   dec_opb;
	logic [XLEN-1:0]   dec_imm;
	logic              dec_wr;
	logic              use_rs1;
	logic              use_rs2;
	logic              wen;
	logic [31:0]       busy_eff;
	logic              stall;
	logic              fire;

	// ******************************************************************
	// fields and immediates
	// ******************************************************************

	assign inst = fetch.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd = inst[11:7];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	// opcode and funct fields to an operation
	always_comb begin
		dec_op = op_nop;
		case (opcode)
			OPC_OP: begin
				case ({funct7, funct3})
					10'b0000000_000: dec_op = op_add;
					10'b0100000_000: dec_op = op_sub;
					10'b0000000_001: dec_op = op_sll;
					10'b0000000_010: dec_op = op_slt;
					10'b0000000_011: dec_op = op_sltu;
					10'b0000000_100: dec_op = op_xor;
					10'b0000000_101: dec_op = op_srl;
					10'b0100000_101: dec_op = op_sra;
					10'b0000000_110: dec_op = op_or;
					10'b0000000_111: dec_op = op_and;
					default: dec_op = op_nop;
				endcase
			end
			OPC_OP_IMM: begin
				case (funct3)
					3'b000: dec_op = op_addi;
					3'b010: dec_op = op_slti;
					3'b011: dec_op = op_sltiu;
					3'b100: dec_op = op_xori;
					3'b110: dec_op = op_ori;
					3'b111: dec_op = op_andi;
					// rv64 shamt is six bits, funct6 above it
					3'b001: dec_op = (inst[31:26] == 6'b000000) ? op_slli : op_nop;
					3'b101: begin
						if (inst[31:26] == 6'b000000)
							dec_op = op_srli;
						else if (inst[31:26] == 6'b010000)
							dec_op = op_srai;
					end
					default: dec_op = op_nop;
				endcase
			end
			OPC_LUI: dec_op = op_lui;
			OPC_AUIPC: dec_op = op_auipc;
			OPC_JAL: dec_op = op_jal;
			OPC_JALR: dec_op = (funct3 == 3'b000) ? op_jalr : op_nop;
			OPC_BRANCH: begin
				case (funct3)
					3'b000: dec_op = op_beq;
					3'b001: dec_op = op_bne;
					3'b100: dec_op = op_blt;
					3'b101: dec_op = op_bge;
					3'b110: dec_op = op_bltu;
					3'b111: dec_op = op_bgeu;
					default: dec_op = op_nop;
				endcase
			end
			default: dec_op = op_nop;
		endcase
	end

	// ******************************************************************
	// operands and alu function
	// ******************************************************************

	always_comb begin
		dec_opa = rs1_data;
		dec_opb = imm_i;
		dec_imm = imm_i;
		dec_wr = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (dec_op)
			op_add, op_sub, op_and, op_or, op_xor,
			op_slt, op_sltu, op_sll, op_srl, op_sra: begin
				dec_opb = rs2_data;
				dec_wr = 1'b1;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			op_addi, op_andi, op_ori, op_xori, op_slti,
			op_sltiu, op_slli, op_srli, op_srai, op_jalr: begin
				dec_wr = 1'b1;
				use_rs1 = 1'b1;
			end
			op_lui: begin
				dec_opb = imm_u;
				dec_wr = 1'b1;
			end
			op_auipc: begin
				dec_opa = fetch.pc;
				dec_opb = imm_u;
				dec_wr = 1'b1;
			end
			op_jal: begin
				// alu forms the target, link made in execute
				dec_opa = fetch.pc;
				dec_opb = imm_j;
				dec_imm = imm_j;
				dec_wr = 1'b1;
			end
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
				dec_imm = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			default: dec_wr = 1'b0;
		endcase
	end

	always_comb begin
		case (dec_op)
			op_sub: dec_alu = alu_sub;
			op_and, op_andi: dec_alu = alu_and;
			op_or, op_ori: dec_alu = alu_or;
			op_xor, op_xori: dec_alu = alu_xor;
			op_slt, op_slti: dec_alu = alu_slt;
			op_sltu, op_sltiu: dec_alu = alu_sltu;
			op_sll, op_slli: dec_alu = alu_sll;
			op_srl, op_srli: dec_alu = alu_srl;
			op_sra, op_srai: dec_alu = alu_sra;
			op_lui: dec_alu = alu_pass_b;
			default: dec_alu = alu_add;
		endcase
	end

	// ******************************************************************
	// scoreboard stall and issue
	// ******************************************************************

	// x0 never waits
	assign busy_eff = {busy[31:1], 1'b0};
	assign wen = dec_wr && (rd != '0);
	// raw on sources, waw on rd
	assign stall = valid_if_id && ((use_rs1 && busy_eff[rs1_addr])
		|| (use_rs2 && busy_eff[rs2_addr]) || (wen && busy_eff[rd]));
	assign ready_if_id = !stall;
	assign fire = valid_if_id && !stall && !redirect.valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			issue.valid <= 1'b0;
		end else begin
			// bubble on stall or redirect
			issue.valid <= fire;
			if (fire) begin
				issue.pc <= fetch.pc;
				issue.op <= dec_op;
				issue.alu <= dec_alu;
				issue.opa <= dec_opa;
				issue.opb <= dec_opb;
				issue.src2 <= rs2_data;
				issue.imm <= dec_imm;
				issue.rd <= rd;
				issue.wen <= wen;
			end
		end
	end

	// writeback relies on this to keep x0 out of the scoreboard
	a_no_x0_wen : assert property (@(posedge clk) disable iff (rst)
		issue.valid |-> !(issue.wen && issue.rd == '0))
		else $error("issue writes x0");

endmodule

/* verilog/npc_exu.sv */
// execute stage: alu, branch compare, jump targets, redirect and the result register
`timescale 1ns/1ps

module npc_exu (
	input  logic               clk,
	input  logic               rst,
	input  npc_pkg::issue_s    issue,
	output npc_pkg::redirect_s redirect,
	output npc_pkg::result_s   result
);
	import npc_pkg::*;

	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] link;
	logic [XLEN-1:0] target;
	logic            taken;
	logic            jump;

	// ******************************************************************
	// alu
	// ******************************************************************

	always_comb begin
		case (issue.alu)
			alu_add: alu_out = issue.opa + issue.opb;
			alu_sub: alu_out = issue.opa - issue.opb;
			alu_and: alu_out = issue.opa & issue.opb;
			alu_or: alu_out = issue.opa | issue.opb;
			alu_xor: alu_out = issue.opa ^ issue.opb;
			alu_slt: alu_out = XLEN'($signed(issue.opa) < $signed(issue.opb));
			alu_sltu: alu_out = XLEN'(issue.opa < issue.opb);
			// six bit shift amount
			alu_sll: alu_out = issue.opa << issue.opb[5:0];
			alu_srl: alu_out = issue.opa >> issue.opb[5:0];
			alu_sra: alu_out = $signed(issue.opa) >>> issue.opb[5:0];
			alu_pass_b: alu_out = issue.opb;
			default: alu_out = issue.opa + issue.opb;
		endcase
	end

	// ******************************************************************
	// control transfer
	// ******************************************************************

	// branch condition on rs1 and rs2
	always_comb begin
		case (issue.op)
			op_beq: taken = issue.opa == issue.src2;
			op_bne: taken = issue.opa != issue.src2;
			op_blt: taken = $signed(issue.opa) < $signed(issue.src2);
			op_bge: taken = $signed(issue.opa) >= $signed(issue.src2);
			op_bltu: taken = issue.opa < issue.src2;
			op_bgeu: taken = issue.opa >= issue.src2;
			default: taken = 1'b0;
		endcase
	end

	assign jump = (issue.op == op_jal) || (issue.op == op_jalr);
	assign link = issue.pc + XLEN'(4);

	always_comb begin
		if (issue.op == op_jalr)
			// low bit of the jalr sum is dropped
			target = {alu_out[XLEN-1:1], 1'b0};
		else if (issue.op == op_jal)
			target = alu_out;
		else
			target = issue.pc + issue.imm;
	end

	// same cycle, fetch and decode flush on it
	assign redirect = '{valid: issue.valid && (taken || jump), target: target};

	// result register
	always_ff @(posedge clk) begin
		if (rst) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= issue.valid;
			if (issue.valid) begin
				result.pc <= issue.pc;
				result.rd <= issue.rd;
				result.wen <= issue.wen;
				result.value <= jump ? link : alu_out;
			end
		end
	end

	// a redirect comes from a live instruction and decode bubbles behind it
	a_redirect_flush : assert property (@(posedge clk) disable iff (rst)
		redirect.valid |-> issue.valid ##1 !issue.valid)
		else $error("redirect without flush of the next issue");

endmodule

/* verilog/npc_wbu.sv */
// writeback stage: commit report, register file write and the register busy scoreboard
`timescale 1ns/1ps

module npc_wbu (
	input  logic                       clk,
	input  logic                       rst,
	input  npc_pkg::result_s           result,
	input  logic                       issue_valid,
	input  logic [npc_pkg::GPR_AW-1:0] issue_rd,
	input  logic                       issue_wen,
	input  logic [npc_pkg::GPR_AW-1:0] rs1_addr,
	input  logic [npc_pkg::GPR_AW-1:0] rs2_addr,
	output logic [npc_pkg::XLEN-1:0]   rs1_data,
	output logic [npc_pkg::XLEN-1:0]   rs2_data,
	output logic [31:0]                busy,
	output npc_pkg::commit_s           commit
);
	import npc_pkg::*;

	logic        gpr_wen;
	logic [31:0] busy_q;
	logic [31:0] set_mask;
	logic [31:0] clr_mask;

	// retire what execute registered last cycle
	assign commit = '{valid: result.valid, pc: result.pc, rd: result.rd,
		wen: result.wen, value: result.value};
	assign gpr_wen = result.valid && result.wen;

	npc_gpr u_npc_gpr (
		.clk    (clk),
		.wen    (gpr_wen),
		.waddr  (result.rd),
		.wdata  (result.value),
		.raddr1 (rs1_addr),
		.raddr2 (rs2_addr),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	// ******************************************************************
	// scoreboard
	// ******************************************************************

	// set by the instruction now in execute, cleared by the write
	assign set_mask = (issue_valid && issue_wen) ? (32'b1 << issue_rd) : '0;
	assign clr_mask = gpr_wen ? (32'b1 << result.rd) : '0;

	always_ff @(posedge clk) begin
		if (rst)
			busy_q <= '0;
		else
			busy_q <= (busy_q & ~clr_mask) | set_mask;
	end

	// the producer in execute already blocks its consumers
	assign busy = busy_q | set_mask;

	a_commit_was_busy : assert property (@(posedge clk) disable iff (rst)
		commit.valid && commit.wen |-> busy_q[commit.rd])
		else $error("commit to a register not marked busy");

endmodule

/* verilog/npc_core.sv */
// core top: connects fetch, decode, execute and writeback to the imem and commit ports
`timescale 1ns/1ps

module npc_core (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [31:0]              imem_data,
	output logic [npc_pkg::XLEN-1:0] imem_addr,
	output npc_pkg::commit_s         commit
);
	import npc_pkg::*;

	// ******************************************************************
	// stage links
	// ******************************************************************

	logic              valid_if_id;
	logic              ready_if_id;
	fetch_s            fetch;
	issue_s            issue;
	redirect_s         redirect;
	result_s           result;
	// register file read and scoreboard, owned by writeback
	logic [GPR_AW-1:0] rs1_addr;
	logic [GPR_AW-1:0] rs2_addr;
	logic [XLEN-1:0]   rs1_data;
	logic [XLEN-1:0]   rs2_data;
	logic [31:0]       busy;

	npc_ifu u_npc_ifu (
		.clk         (clk),
		.rst         (rst),
		.redirect    (redirect),
		.ready_if_id (ready_if_id),
		.imem_data   (imem_data),
		.imem_addr   (imem_addr),
		.valid_if_id (valid_if_id),
		.fetch       (fetch)
	);

	npc_idu u_npc_idu (
		.clk         (clk),
		.rst         (rst),
		.valid_if_id (valid_if_id),
		.fetch       (fetch),
		.redirect    (redirect),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.busy        (busy),
		.ready_if_id (ready_if_id),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.issue       (issue)
	);

	npc_exu u_npc_exu (
		.clk      (clk),
		.rst      (rst),
		.issue    (issue),
		.redirect (redirect),
		.result   (result)
	);

	npc_wbu u_npc_wbu (
		.clk         (clk),
		.rst         (rst),
		.result      (result),
		.issue_valid (issue.valid),
		.issue_rd    (issue.rd),
		.issue_wen   (issue.wen),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.busy        (busy),
		.commit      (commit)
	);

endmodule

/* tb/npc_tb.sv */
// testbench for the npc core: imem model, reference model and directed program tests
`timescale 1ns/1ps

module npc_tb;
	import npc_pkg::*;

	logic               clk;
	logic               rst;
	logic [31:0]        imem_data;
	logic [XLEN-1:0]    imem_addr;
	commit_s            commit;

	// 256 word program memory at RESET_PC, aliased above that
	logic [31:0]        imem [0:255];
	int                 prog_len;
	logic [XLEN-1:0]    halt_pc;

	// expected commit list from the reference model
	logic [XLEN-1:0]    exp_pc [$];
	logic [GPR_AW-1:0]  exp_rd [$];
	logic               exp_wen [$];
	logic [XLEN-1:0]    exp_val [$];

	int                 seed;
	int                 errors;
	// watchdog cycle budget, grows with each test
	int                 budget;
	int                 cycles;

	npc_core u_npc_core (
		.clk       (clk),
		.rst       (rst),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.commit    (commit)
	);

	// combinational read port
	assign imem_data = imem[imem_addr[9:2]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ******************************************************************
	// error reporting and watchdog
	// ******************************************************************

	task automatic report_error(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] want);
		errors++;
		$display("error at %0t ns: %s got %h expected %h", $time, what, got, want);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	initial begin
		cycles = 0;
		while (cycles <= budget)
			@(posedge clk) cycles++;
		$display("timeout: the core stopped committing after %0d cycles", cycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

	// ******************************************************************
	// instruction encoders
	// ******************************************************************

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// byte offset, bit 0 ignored
	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	// random 64 bit value into rd, tmp gets clobbered
	task automatic emit_rand64(input logic [4:0] rd, input logic [4:0] tmp);
		emit(enc_u($random(seed), rd, OPC_LUI));
		emit(enc_i($random(seed), rd, 3'b000, rd, OPC_OP_IMM));
		emit(enc_i(12'd32, rd, 3'b001, rd, OPC_OP_IMM));
		emit(enc_u($random(seed), tmp, OPC_LUI));
		emit(enc_i($random(seed), tmp, 3'b000, tmp, OPC_OP_IMM));
		emit(enc_r(7'h00, tmp, rd, 3'b100, rd));
	endtask

	// ******************************************************************
	// reference model
	// ******************************************************************

	function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
		return {{(XLEN-12){v[11]}}, v};
	endfunction

	task automatic model_run();
		logic [XLEN-1:0] regs [0:31];
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] next;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] val;
		logic [31:0]     inst;
		logic [2:0]      f3;
		logic            wr;
		logic            take;
		int              steps;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		exp_pc.delete();
		exp_rd.delete();
		exp_wen.delete();
		exp_val.delete();
		pc = RESET_PC;
		steps = 0;
		while (pc != halt_pc && steps < 400) begin
			inst = imem[pc[9:2]];
			f3 = inst[14:12];
			a = regs[inst[19:15]];
			b = regs[inst[24:20]];
			imm = sext12(inst[31:20]);
			next = pc + 4;
			wr = 1'b0;
			val = '0;
			take = 1'b0;
			case (inst[6:0])
				OPC_OP: begin
					wr = 1'b1;
					case ({inst[31:25], f3})
						10'h000: val = a + b;
						10'h100: val = a - b;
						10'h001: val = a << b[5:0];
						10'h002: val = ($signed(a) < $signed(b)) ? 1 : 0;
						10'h003: val = (a < b) ? 1 : 0;
						10'h004: val = a ^ b;
						10'h005: val = a >> b[5:0];
						10'h105: val = $signed(a) >>> b[5:0];
						10'h006: val = a | b;
						10'h007: val = a & b;
						default: wr = 1'b0;
					endcase
				end
				OPC_OP_IMM: begin
					wr = 1'b1;
					case (f3)
						3'b000: val = a + imm;
						3'b010: val = ($signed(a) < $signed(imm)) ? 1 : 0;
						3'b011: val = (a < imm) ? 1 : 0;
						3'b100: val = a ^ imm;
						3'b110: val = a | imm;
						3'b111: val = a & imm;
						3'b001: begin
							wr = (inst[31:26] == 6'h00);
							val = a << inst[25:20];
						end
						default: begin
							wr = (inst[31:26] == 6'h00) || (inst[31:26] == 6'h10);
							if (inst[30])
								val = $signed(a) >>> inst[25:20];
							else
								val = a >> inst[25:20];
						end
					endcase
				end
				OPC_LUI: begin
					wr = 1'b1;
					val = {{32{inst[31]}}, inst[31:12], 12'h000};
				end
				OPC_AUIPC: begin
					wr = 1'b1;
					val = pc + {{32{inst[31]}}, inst[31:12], 12'h000};
				end
				OPC_JAL: begin
					wr = 1'b1;
					val = pc + 4;
					next = pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
				end
				OPC_JALR: begin
					if (f3 == 3'b000) begin
						wr = 1'b1;
						val = pc + 4;
						next = (a + imm) & ~64'h1;
					end
				end
				OPC_BRANCH: begin
					case (f3)
						3'b000: take = (a == b);
						3'b001: take = (a != b);
						3'b100: take = $signed(a) < $signed(b);
						3'b101: take = $signed(a) >= $signed(b);
						3'b110: take = a < b;
						3'b111: take = a >= b;
						default: take = 1'b0;
					endcase
					if (take)
						next = pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				end
				default: wr = 1'b0;
			endcase
			wr = wr && (inst[11:7] != 5'd0);
			if (wr)
				regs[inst[11:7]] = val;
			exp_pc.push_back(pc);
			exp_rd.push_back(inst[11:7]);
			exp_wen.push_back(wr);
			exp_val.push_back(val);
			pc = next;
			steps++;
		end
	endtask

	// ******************************************************************
	// test framework
	// ******************************************************************

	// reset on, memory filled with unsupported words that vary by address
	task automatic begin_program();
		@(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < 256; i++)
			imem[i] = ((i + 1) * 32'h9e37_79b1) | 32'h7f;
		prog_len = 0;
	endtask

	task automatic run_program(input string name);
		int idx;
		halt_pc = RESET_PC + 4 * prog_len;
		// spin in place once the program is done
		emit(enc_j(21'd0, 5'd0));
		model_run();
		budget += 20 * exp_pc.size() + 40;
		$display("running %s, %0d commits expected", name, exp_pc.size());
		repeat (8) begin
			@(negedge clk);
			assert (!commit.valid) else report_error("commit valid in reset", 1, 0);
		end
		rst = 1'b0;
		assert (imem_addr == RESET_PC) else report_error("first fetch address", imem_addr,
			RESET_PC);
		assert (!commit.valid) else report_error("early commit", 1, 0);
		repeat (2) begin
			@(negedge clk);
			assert (!commit.valid) else report_error("early commit", 1, 0);
		end
		idx = 0;
		while (idx < exp_pc.size()) begin
			@(negedge clk);
			if (commit.valid) begin
				assert (commit.pc == exp_pc[idx])
					else report_error("commit pc", commit.pc, exp_pc[idx]);
				assert (commit.rd == exp_rd[idx])
					else report_error("commit rd", commit.rd, exp_rd[idx]);
				assert (commit.wen == exp_wen[idx])
					else report_error("commit wen", commit.wen, exp_wen[idx]);
				// value only means something when a register is written
				if (exp_wen[idx])
					assert (commit.value == exp_val[idx])
						else report_error("commit value", commit.value, exp_val[idx]);
				idx++;
			end
		end
		// only the halt loop may retire afterwards
		repeat (12) begin
			@(negedge clk);
			if (commit.valid)
				assert (commit.pc == halt_pc && !commit.wen)
					else report_error("commit after program end", commit.pc, halt_pc);
		end
	endtask

	// ******************************************************************
	// directed tests
	// ******************************************************************

	task automatic test_alu();
		logic [5:0] shamt;
		for (int round = 0; round < 3; round++) begin
			begin_program();
			emit_rand64(5'd1, 5'd3);
			emit_rand64(5'd2, 5'd3);
			// register forms
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
			emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd9));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd10));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd11));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd12));
			emit(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd13));
			emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd14));
			// both orders for the compares
			emit(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd15));
			emit(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd16));
			// immediate forms
			emit(enc_i($random(seed), 5'd1, 3'b000, 5'd17, OPC_OP_IMM));
			emit(enc_i($random(seed), 5'd1, 3'b010, 5'd18, OPC_OP_IMM));
			emit(enc_i($random(seed), 5'd1, 3'b011, 5'd19, OPC_OP_IMM));
			emit(enc_i($random(seed), 5'd1, 3'b100, 5'd20, OPC_OP_IMM));
			emit(enc_i($random(seed), 5'd1, 3'b110, 5'd21, OPC_OP_IMM));
			emit(enc_i($random(seed), 5'd1, 3'b111, 5'd22, OPC_OP_IMM));
			shamt = $random(seed);
			emit(enc_i({6'h00, shamt}, 5'd1, 3'b001, 5'd23, OPC_OP_IMM));
			shamt = $random(seed);
			emit(enc_i({6'h00, shamt}, 5'd1, 3'b101, 5'd24, OPC_OP_IMM));
			shamt = $random(seed);
			emit(enc_i({6'h10, shamt}, 5'd1, 3'b101, 5'd25, OPC_OP_IMM));
			run_program("alu");
		end
	endtask

	task automatic test_deps();
		begin_program();
		emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
		emit(enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
		emit(enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
		emit(enc_r(7'h00, 5'd1, 5'd4, 3'b001, 5'd5));
		emit(enc_r(7'h00, 5'd4, 5'd5, 3'b100, 5'd1));
		// same register written back to back
		for (int i = 0; i < 6; i++)
			emit(enc_i(12'hfff, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd6));
		emit(enc_i(12'd3, 5'd6, 3'b101, 5'd7, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd7, 5'd6, 3'b011, 5'd8));
		run_program("dependencies");
	endtask

	task automatic test_branches();
		logic [2:0]  conds [6];
		logic [11:0] lhs [4];
		logic [11:0] rhs [4];
		conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		// equal, signed and unsigned order disagree, plain less
		lhs = '{12'd5, 12'hfff, 12'd1, 12'd3};
		rhs = '{12'd5, 12'd1, 12'hfff, 12'd7};
		begin_program();
		// counters start from zero, registers survive reset
		emit(enc_i(12'd0, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
		emit(enc_i(12'd0, 5'd0, 3'b000, 5'd11, OPC_OP_IMM));
		emit(enc_i(12'd0, 5'd0, 3'b000, 5'd12, OPC_OP_IMM));
		foreach (conds[c]) begin
			for (int p = 0; p < 4; p++) begin
				emit(enc_i(lhs[p], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
				emit(enc_i(rhs[p], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
				emit(enc_b(13'd12, 5'd2, 5'd1, conds[c]));
				emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, OPC_OP_IMM));
				emit(enc_i(12'd1, 5'd11, 3'b000, 5'd11, OPC_OP_IMM));
				emit(enc_i(12'd1, 5'd12, 3'b000, 5'd12, OPC_OP_IMM));
			end
		end
		run_program("branches");
	endtask

	task automatic test_jumps();
		begin_program();
		emit(enc_u($random(seed), 5'd1, OPC_LUI));
		emit(enc_u($random(seed), 5'd2, OPC_AUIPC));
		emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd3));
		emit(enc_j(21'd12, 5'd5));
		emit(enc_i(12'd1, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
		emit(enc_i(12'd2, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
		emit(enc_u(20'd0, 5'd6, OPC_AUIPC));
		// odd offset, target lands two words past the jalr
		emit(enc_i(12'd13, 5'd6, 3'b000, 5'd7, OPC_JALR));
		emit(enc_i(12'd3, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd5, 5'd7, 3'b000, 5'd8));
		emit(enc_j(21'd8, 5'd0));
		emit(enc_i(12'd4, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd10));
		emit(enc_u(20'h12345, 5'd0, OPC_LUI));
		emit(enc_r(7'h00, 5'd8, 5'd0, 3'b000, 5'd11));
		run_program("jumps and upper immediates");
	endtask

	task automatic test_unsupported();
		begin_program();
		emit(enc_i(12'd7, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
		// known x2, the load below must leave it alone
		emit(enc_i(12'd9, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
		emit(32'h0000_0073);
		// load, mul, reserved branch and bad shift funct6
		emit(enc_i(12'd0, 5'd1, 3'b010, 5'd2, 7'b0000011));
		emit(enc_r(7'h01, 5'd1, 5'd1, 3'b000, 5'd3));
		emit(enc_b(13'd8, 5'd1, 5'd1, 3'b010));
		emit(enc_i({6'h20, 6'd3}, 5'd1, 3'b001, 5'd4, OPC_OP_IMM));
		emit(enc_i(12'd1, 5'd1, 3'b000, 5'd5, OPC_OP_IMM));
		emit(enc_r(7'h00, 5'd2, 5'd5, 3'b000, 5'd6));
		run_program("unsupported encodings");
	endtask

	// ******************************************************************
	// sequence
	// ******************************************************************

	initial begin
		rst = 1'b1;
		seed = 32'hd0897251;
		errors = 0;
		budget = 100;
		prog_len = 0;
		halt_pc = RESET_PC;
		test_alu();
		test_deps();
		test_branches();
		test_jumps();
		test_unsupported();
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("TESTBENCH FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

/* files.f */
verilog/npc_pkg.sv
verilog/npc_gpr.sv
verilog/npc_ifu.sv
verilog/npc_idu.sv
verilog/npc_exu.sv
verilog/npc_wbu.sv
verilog/npc_core.sv
tb/npc_tb.sv
